/* all.f */
+incdir+include
rtl/core_pkg.sv
rtl/inst_decode.sv
rtl/gpr_file.sv
rtl/alu.sv
rtl/exec_unit.sv
rtl/core_top.sv
bench/core_properties.sv
bench/core_tb.sv

/* bench/core_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module core_properties (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input logic wb_valid,
	input logic illegal
);

	////////////////////////////////////////////////////////////
	// Report flags
	////////////////////////////////////////////////////////////

	property p_exclusive;
		@(posedge clk) disable iff (!rst_n) !(wb_valid && illegal);
	endproperty

	// One report per accepted word, one cycle later.
	property p_report_after_valid;
		@(posedge clk) disable iff (!rst_n) inst_valid |=> (wb_valid || illegal);
	endproperty

	property p_quiet_after_idle;
		@(posedge clk) disable iff (!rst_n) !inst_valid |=> !(wb_valid || illegal);
	endproperty

	property p_quiet_in_reset;
		@(posedge clk) !rst_n |-> (!wb_valid && !illegal);
	endproperty

	a_exclusive: assert property (p_exclusive)
		else $error("wb_valid and illegal high in the same cycle");
	a_report_after_valid: assert property (p_report_after_valid)
		else $error("no report one cycle after inst_valid");
	a_quiet_after_idle: assert property (p_quiet_after_idle)
		else $error("report without inst_valid one cycle earlier");
	a_quiet_in_reset: assert property (p_quiet_in_reset)
		else $error("report flag high while in reset");

endmodule

`default_nettype wire

/* bench/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_macros.svh"

module core_tb import core_pkg::*; ();

	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 4;
	localparam int IDLE_CHECKS   = 3;
	localparam int MAX_GAP       = 3;
	localparam int MARGIN_CYCLES = 20;
	localparam int SEED          = 69227;

	typedef struct {
		data_t     inst;
		bit        legal;
		reg_addr_t rd;
		data_t     data;
		bit        chain;
	} test_entry_t;

	logic      clk;
	logic      rst_n;
	data_t     inst;
	logic      inst_valid;
	logic      wb_valid;
	reg_addr_t wb_rd;
	data_t     wb_data;
	logic      illegal;

	test_entry_t tests[$];
	bit          table_ready;
	int          cur_test;

	core_top i_core_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.inst_valid (inst_valid),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.illegal    (illegal)
	);

	bind core_top core_properties i_core_properties (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.wb_valid   (wb_valid),
		.illegal    (illegal)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Encoders and checks
	////////////////////////////////////////////////////////////

	function automatic data_t enc_itype(input logic [2:0] funct3, input reg_addr_t rd,
			input reg_addr_t rs1, input logic [11:0] imm);
		return {imm, rs1, funct3, rd, `OP_IMM};
	endfunction

	function automatic data_t enc_rtype(input logic [6:0] funct7, input logic [2:0] funct3,
			input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		return {funct7, rs2, rs1, funct3, rd, `OP_REG};
	endfunction

	task automatic stop_on_error();
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("error: %s got 0x%08h expected 0x%08h (test %0d)", name, got, exp, cur_test);
			stop_on_error();
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("error: %s got 0x%02h expected 0x%02h (test %0d)", name, got, exp, cur_test);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: %s got 0x%0h expected 0x%0h (test %0d)", name, got, exp, cur_test);
			stop_on_error();
		end
	endtask

	task automatic check_quiet();
		check_flag("wb_valid", wb_valid, 1'b0);
		check_flag("illegal", illegal, 1'b0);
	endtask

	task automatic check_entry(input test_entry_t e);
		if (e.legal) begin
			check_flag("wb_valid", wb_valid, 1'b1);
			check_flag("illegal", illegal, 1'b0);
			check_reg("wb_rd", wb_rd, e.rd);
			check_data("wb_data", wb_data, e.data);
		end else begin
			check_flag("wb_valid", wb_valid, 1'b0);
			check_flag("illegal", illegal, 1'b1);
		end
	endtask

	task automatic drive_entry(input int idx);
		inst       <= tests[idx].inst;
		inst_valid <= 1'b1;
	endtask

	task automatic drive_idle();
		inst       <= '0;
		inst_valid <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	task automatic add_entry(input data_t w, input bit legal, input reg_addr_t rd,
			input data_t data, input bit chain);
		test_entry_t e;
		e.inst  = w;
		e.legal = legal;
		e.rd    = rd;
		e.data  = data;
		e.chain = chain;
		tests.push_back(e);
	endtask

	task automatic build_table();
		add_entry(enc_itype(3'b000, 5'd1, 5'd0, 12'h123), 1'b1, 5'd1, 32'h0000_0123, 1'b0);
		add_entry(enc_itype(3'b000, 5'd2, 5'd0, 12'hffb), 1'b1, 5'd2, 32'hffff_fffb, 1'b0);
		add_entry(enc_itype(3'b000, 5'd3, 5'd0, 12'h7ff), 1'b1, 5'd3, 32'h0000_07ff, 1'b0);
		add_entry(enc_itype(3'b000, 5'd4, 5'd1, 12'h010), 1'b1, 5'd4, 32'h0000_0133, 1'b0);
		add_entry(enc_itype(3'b000, 5'd5, 5'd2, 12'hffd), 1'b1, 5'd5, 32'hffff_fff8, 1'b0);
		// Same negative operand, signed then unsigned.
		add_entry(enc_itype(3'b010, 5'd6, 5'd2, 12'h001), 1'b1, 5'd6, 32'h0000_0001, 1'b0);
		add_entry(enc_itype(3'b011, 5'd7, 5'd2, 12'h001), 1'b1, 5'd7, 32'h0000_0000, 1'b0);
		add_entry(enc_itype(3'b011, 5'd9, 5'd1, 12'hfff), 1'b1, 5'd9, 32'h0000_0001, 1'b0);
		add_entry(enc_itype(3'b100, 5'd10, 5'd1, 12'h0ff), 1'b1, 5'd10, 32'h0000_01dc, 1'b0);
		add_entry(enc_itype(3'b110, 5'd11, 5'd1, 12'h40c), 1'b1, 5'd11, 32'h0000_052f, 1'b0);
		add_entry(enc_itype(3'b111, 5'd12, 5'd2, 12'h0f0), 1'b1, 5'd12, 32'h0000_00f0, 1'b0);
		add_entry(enc_itype(3'b100, 5'd13, 5'd3, 12'hfff), 1'b1, 5'd13, 32'hffff_f800, 1'b0);
		// Shift immediates on a word with bit 31 set.
		add_entry(enc_itype(3'b001, 5'd14, 5'd1, {7'h00, 5'd23}), 1'b1, 5'd14, 32'h9180_0000, 1'b0);
		add_entry(enc_itype(3'b101, 5'd15, 5'd14, {7'h00, 5'd4}), 1'b1, 5'd15, 32'h0918_0000, 1'b0);
		add_entry(enc_itype(3'b101, 5'd16, 5'd14, {7'h20, 5'd4}), 1'b1, 5'd16, 32'hf918_0000, 1'b0);
		add_entry(enc_itype(3'b101, 5'd18, 5'd14, {7'h20, 5'd31}), 1'b1, 5'd18, 32'hffff_ffff, 1'b0);
		// Register-register group, dependents issued back to back.
		add_entry(enc_rtype(7'h00, 3'b000, 5'd20, 5'd1, 5'd3), 1'b1, 5'd20, 32'h0000_0922, 1'b1);
		add_entry(enc_rtype(7'h20, 3'b000, 5'd21, 5'd20, 5'd1), 1'b1, 5'd21, 32'h0000_07ff, 1'b1);
		add_entry(enc_rtype(7'h00, 3'b001, 5'd22, 5'd21, 5'd6), 1'b1, 5'd22, 32'h0000_0ffe, 1'b0);
		add_entry(enc_rtype(7'h00, 3'b010, 5'd23, 5'd2, 5'd1), 1'b1, 5'd23, 32'h0000_0001, 1'b0);
		add_entry(enc_rtype(7'h00, 3'b011, 5'd24, 5'd2, 5'd1), 1'b1, 5'd24, 32'h0000_0000, 1'b0);
		add_entry(enc_rtype(7'h00, 3'b100, 5'd25, 5'd22, 5'd1), 1'b1, 5'd25, 32'h0000_0edd, 1'b0);
		add_entry(enc_rtype(7'h00, 3'b101, 5'd26, 5'd14, 5'd2), 1'b1, 5'd26, 32'h0000_0012, 1'b0);
		add_entry(enc_rtype(7'h20, 3'b101, 5'd27, 5'd14, 5'd2), 1'b1, 5'd27, 32'hffff_fff2, 1'b0);
		add_entry(enc_rtype(7'h00, 3'b110, 5'd28, 5'd1, 5'd14), 1'b1, 5'd28, 32'h9180_0123, 1'b0);
		add_entry(enc_rtype(7'h00, 3'b111, 5'd29, 5'd2, 5'd14), 1'b1, 5'd29, 32'h9180_0000, 1'b0);
		add_entry(enc_rtype(7'h20, 3'b000, 5'd30, 5'd1, 5'd3), 1'b1, 5'd30, 32'hffff_f924, 1'b1);
		add_entry(enc_rtype(7'h00, 3'b000, 5'd31, 5'd30, 5'd3), 1'b1, 5'd31, 32'h0000_0123, 1'b0);
		// x0 reports its result but still reads zero.
		add_entry(enc_itype(3'b000, 5'd0, 5'd1, 12'h055), 1'b1, 5'd0, 32'h0000_0178, 1'b1);
		add_entry(enc_rtype(7'h00, 3'b000, 5'd19, 5'd0, 5'd1), 1'b1, 5'd19, 32'h0000_0123, 1'b0);
		// Unsupported words aimed at x1.
		add_entry({20'habcde, 5'd1, 7'b0110111}, 1'b0, 5'd0, 32'h0, 1'b0);
		add_entry(enc_itype(3'b001, 5'd1, 5'd2, {7'h20, 5'd3}), 1'b0, 5'd0, 32'h0, 1'b0);
		add_entry(enc_rtype(7'h01, 3'b000, 5'd1, 5'd2, 5'd3), 1'b0, 5'd0, 32'h0, 1'b1);
		add_entry(enc_itype(3'b000, 5'd19, 5'd1, 12'h000), 1'b1, 5'd19, 32'h0000_0123, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int gap;
		clk         = 1'b0;
		rst_n       = 1'b0;
		inst        = '0;
		inst_valid  = 1'b0;
		cur_test    = -1;
		void'($urandom(SEED));
		build_table();
		table_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		repeat (IDLE_CHECKS) begin
			@(negedge clk);
			check_quiet();
			check_reg("wb_rd", wb_rd, '0);
			check_data("wb_data", wb_data, '0);
		end

		@(posedge clk);
		drive_entry(0);
		for (int i = 0; i < tests.size(); i++) begin
			@(posedge clk);
			gap = tests[i].chain ? 0 : int'($urandom_range(MAX_GAP, 0));
			if (gap == 0 && i + 1 < tests.size()) begin
				drive_entry(i + 1);
			end else begin
				drive_idle();
			end
			@(negedge clk);
			cur_test = i;
			check_entry(tests[i]);
			if (gap != 0 && i + 1 < tests.size()) begin
				// Nothing reported while idle.
				repeat (gap) begin
					@(negedge clk);
					check_quiet();
				end
				@(posedge clk);
				drive_entry(i + 1);
			end
		end

		$display("NO ERRORS");
		$finish;
	end

	initial begin
		int limit_cycles;
		wait (table_ready);
		limit_cycles = RESET_CYCLES + IDLE_CHECKS + MARGIN_CYCLES
			+ tests.size() * (MAX_GAP + 3);
		#(limit_cycles * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		$display("ERRORS FOUND");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* include/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath and register file sizes.
`define XLEN        32
`define NUM_REGS    32
`define REG_ADDR_W  5

// Major opcodes of the two supported groups.
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011

`endif

/* rtl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu import core_pkg::*; (
	input  data_t   a,
	input  data_t   b,
	input  alu_op_t op,
	output data_t   res
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// Shifts use the low five bits only.
	assign shamt = b[4:0];

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			ALU_ADD: begin
				res = a + b;
			end
			ALU_SUB: begin
				res = a - b;
			end
			ALU_SLL: begin
				res = a << shamt;
			end
			ALU_SRL: begin
				res = a >> shamt;
			end
			ALU_SRA: begin
				res = data_t'($signed(a) >>> shamt);
			end
			ALU_SLT: begin
				res = data_t'(lt_signed);
			end
			ALU_SLTU: begin
				res = data_t'(lt_unsigned);
			end
			ALU_XOR: res = a ^ b;
			ALU_OR:  res = a | b;
			ALU_AND: res = a & b;
			default: res = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package core_pkg;

	////////////////////////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////////////////////////

	typedef logic [`XLEN-1:0]       data_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	////////////////////////////////////////////////////////////
	// ALU operations
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_t;

endpackage

`default_nettype wire

/* rtl/core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  data_t     inst,
	input  logic      inst_valid,
	output logic      wb_valid,
	output reg_addr_t wb_rd,
	output data_t     wb_data,
	output logic      illegal
);

	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	data_t     imm;
	logic      use_imm;
	alu_op_t   alu_op;
	logic      legal;
	logic      illegal_in;

	inst_decode i_inst_decode (
		.inst       (inst),
		.inst_valid (inst_valid),
		.rs1        (rs1),
		.rs2        (rs2),
		.rd         (rd),
		.imm        (imm),
		.use_imm    (use_imm),
		.alu_op     (alu_op),
		.legal      (legal),
		.illegal_in (illegal_in)
	);

	// Single cycle from decode to registered report.
	exec_unit i_exec_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs1        (rs1),
		.rs2        (rs2),
		.rd         (rd),
		.imm        (imm),
		.use_imm    (use_imm),
		.alu_op     (alu_op),
		.legal      (legal),
		.illegal_in (illegal_in),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.illegal    (illegal)
	);

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	input  reg_addr_t rd,
	input  data_t     imm,
	input  logic      use_imm,
	input  alu_op_t   alu_op,
	input  logic      legal,
	input  logic      illegal_in,
	output logic      wb_valid,
	output reg_addr_t wb_rd,
	output data_t     wb_data,
	output logic      illegal
);

	data_t rs1_val;
	data_t rs2_val;
	data_t operand_b;
	data_t alu_res;

	////////////////////////////////////////////////////////////
	// Operand fetch and write-back
	////////////////////////////////////////////////////////////

	gpr_file i_gpr_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr_a (rs1),
		.raddr_b (rs2),
		.waddr   (rd),
		.we      (legal),
		.wdata   (alu_res),
		.rdata_a (rs1_val),
		.rdata_b (rs2_val)
	);

	assign operand_b = use_imm ? imm : rs2_val;

	alu i_alu (
		.a   (rs1_val),
		.b   (operand_b),
		.op  (alu_op),
		.res (alu_res)
	);

	////////////////////////////////////////////////////////////
	// Write-back report
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			illegal  <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= '0;
		end else begin
			wb_valid <= legal;
			illegal  <= illegal_in;
			// Last report held until the next legal word.
			if (legal) begin
				wb_rd   <= rd;
				wb_data <= alu_res;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/gpr_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_macros.svh"

module gpr_file import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t raddr_a,
	input  reg_addr_t raddr_b,
	input  reg_addr_t waddr,
	input  logic      we,
	input  data_t     wdata,
	output data_t     rdata_a,
	output data_t     rdata_b
);

	data_t regs [`NUM_REGS];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			// x0 is never written.
			regs[waddr] <= wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////

	// x0 reads as zero.
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

/* rtl/inst_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_macros.svh"

module inst_decode import core_pkg::*; (
	input  data_t     inst,
	input  logic      inst_valid,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output reg_addr_t rd,
	output data_t     imm,
	output logic      use_imm,
	output alu_op_t   alu_op,
	output logic      legal,
	output logic      illegal_in
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       supported;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign rd  = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];

	always_comb begin
		supported = 1'b0;
		use_imm   = 1'b0;
		alu_op    = ALU_ADD;
		// I-type immediate, sign-extended.
		imm       = {{(`XLEN-12){inst[31]}}, inst[31:20]};
		case (opcode)
			`OP_IMM: begin
				use_imm   = 1'b1;
				supported = 1'b1;
				case (funct3)
					3'b000: alu_op = ALU_ADD;
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
					3'b001: begin
						alu_op    = ALU_SLL;
						imm       = data_t'(inst[24:20]);
						supported = (funct7 == 7'b0000000);
					end
					3'b101: begin
						// Shift amount only; bit 30 picks arithmetic.
						alu_op    = funct7[5] ? ALU_SRA : ALU_SRL;
						imm       = data_t'(inst[24:20]);
						supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					end
				endcase
			end
			`OP_REG: begin
				supported = (funct7 == 7'b0000000);
				case (funct3)
					3'b000: begin
						alu_op    = funct7[5] ? ALU_SUB : ALU_ADD;
						supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					end
					3'b001: alu_op = ALU_SLL;
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b101: begin
						alu_op    = funct7[5] ? ALU_SRA : ALU_SRL;
						supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					end
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
				endcase
			end
			default: supported = 1'b0;
		endcase
	end

	assign legal      = inst_valid & supported;
	assign illegal_in = inst_valid & ~supported;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module core_tb -f all.f -o core_sim

# A failing run exits non-zero; the log decides the outcome.
./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
